/* compile.f */
source/mctl_pkg.sv
source/inst_fetch.sv
source/op_config.sv
source/useq.sv
source/agu.sv
source/matrix_ctrl.sv
verif/matrix_ctrl_assert.sv
verif/tb_matrix_ctrl.sv

/* run.sh */
#!/bin/sh
# builds tb_matrix_ctrl with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_matrix_ctrl -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* source/agu.sv */
`timescale 1ns/1ps

module agu (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          ex_start,
    input  logic [mctl_pkg::start_w-1:0]  a_start,
    input  logic [mctl_pkg::start_w-1:0]  b_start,
    input  logic [mctl_pkg::start_w-1:0]  d_start,
    input  logic [1:0]                    wr_src,
    input  logic [1:0]                    wr_bank,
    input  logic                          mac_en,
    input  logic                          step_ab,
    input  logic                          wen,
    input  logic                          step_d,
    input  logic [mctl_pkg::data_w-1:0]   macs_result,
    input  logic [mctl_pkg::data_w-1:0]   data_encode,
    input  logic [mctl_pkg::data_w-1:0]   data_decode,
    output logic [mctl_pkg::addr_w-1:0]   bank0_addr,
    output logic [mctl_pkg::addr_w-1:0]   bank1_addr,
    output logic [mctl_pkg::addr_w-1:0]   bank2_addr,
    output logic [mctl_pkg::addr_w-1:0]   bank3_addr,
    output logic                          bank0_wr_en,
    output logic                          bank1_wr_en,
    output logic                          bank2_wr_en,
    output logic                          bank3_wr_en,
    output logic [mctl_pkg::data_w-1:0]   wr_data
);

    logic [mctl_pkg::addr_w-1:0] a_cnt;
    logic [mctl_pkg::addr_w-1:0] b_cnt;
    logic [mctl_pkg::addr_w-1:0] d_cnt;
    logic [mctl_pkg::addr_w-1:0] port_addr [4];

    // bank bits stay in the start registers, counters walk inside the bank
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            a_cnt <= '0;
            b_cnt <= '0;
            d_cnt <= '0;
        end else if (ex_start) begin
            a_cnt <= a_start[mctl_pkg::addr_w-1:0];
            b_cnt <= b_start[mctl_pkg::addr_w-1:0];
            d_cnt <= d_start[mctl_pkg::addr_w-1:0];
        end else begin
            if (step_ab) begin
                a_cnt <= a_cnt + 1;
                b_cnt <= b_cnt + 1;
            end
            if (step_d)
                d_cnt <= d_cnt + 1;   // next write slot
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (wen && d_start[mctl_pkg::start_w-1:mctl_pkg::addr_w] == 2'(k))
                port_addr[k] = d_cnt;
            else if (mac_en && a_start[mctl_pkg::start_w-1:mctl_pkg::addr_w] == 2'(k))
                port_addr[k] = a_cnt;
            else if (mac_en && b_start[mctl_pkg::start_w-1:mctl_pkg::addr_w] == 2'(k))
                port_addr[k] = b_cnt;
            else
                port_addr[k] = '0;
        end
    end

    assign bank0_addr = port_addr[0];
    assign bank1_addr = port_addr[1];
    assign bank2_addr = port_addr[2];
    assign bank3_addr = port_addr[3];

    assign bank0_wr_en = wen && (wr_bank == 2'd0);
    assign bank1_wr_en = wen && (wr_bank == 2'd1);
    assign bank2_wr_en = wen && (wr_bank == 2'd2);
    assign bank3_wr_en = wen && (wr_bank == 2'd3);

    always_comb begin
        case (wr_src)
            mctl_pkg::src_mac: wr_data = macs_result;
            mctl_pkg::src_enc: wr_data = data_encode;
            mctl_pkg::src_dec: wr_data = data_decode;
            default:           wr_data = '0;
        endcase
    end

endmodule

/* source/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [mctl_pkg::inst_w-1:0]    inst,
    input  logic                           inst_req,
    output logic                           inst_ack,
    output logic [mctl_pkg::tbl_idx_w-1:0] tbl_addr,
    input  logic [mctl_pkg::start_w-1:0]   tbl_rdata,
    output logic [2:0]                     opcode,
    output logic                           flag,
    output logic [mctl_pkg::start_w-1:0]   start_word,
    output logic                           ld_a,
    output logic                           ld_b,
    output logic                           ld_c,
    output logic                           ld_op,
    output logic                           ex_start,
    input  logic                           done,
    output logic                           busy
);

    logic [1:0]                    phase;
    logic [1:0]                    phase_nxt;
    logic [2:0]                    id_cnt;
    logic [mctl_pkg::inst_w-1:0]   inst_q;
    logic                          accept;
    logic                          in_id;

    // ack still high means the previous handshake has not closed
    assign accept = (phase == mctl_pkg::ph_if) && inst_req && !inst_ack;
    assign in_id  = (phase == mctl_pkg::ph_id);

    always_comb begin
        phase_nxt = phase;
        case (phase)
            mctl_pkg::ph_idle: phase_nxt = mctl_pkg::ph_if;
            mctl_pkg::ph_if:   if (accept) phase_nxt = mctl_pkg::ph_id;
            mctl_pkg::ph_id:   if (id_cnt == mctl_pkg::id_cycles) phase_nxt = mctl_pkg::ph_ex;
            mctl_pkg::ph_ex:   if (done) phase_nxt = mctl_pkg::ph_idle;
            default:           phase_nxt = mctl_pkg::ph_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase    <= mctl_pkg::ph_idle;
            inst_ack <= 1'b0;
            id_cnt   <= '0;
            ex_start <= 1'b0;
        end else begin
            phase <= phase_nxt;
            if (accept)
                inst_ack <= 1'b1;
            else if (!inst_req)
                inst_ack <= 1'b0;   // four-phase return to zero
            id_cnt   <= in_id ? id_cnt + 1 : '0;
            ex_start <= in_id && (id_cnt == mctl_pkg::id_cycles); // count 6 is the handover
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            inst_q <= inst;
    end

    // table index goes out one cycle ahead of its data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tbl_addr <= '0;
        end else if (in_id) begin
            case (id_cnt)
                3'd0:    tbl_addr <= inst_q[23:20];
                3'd1:    tbl_addr <= inst_q[19:16];
                3'd2:    tbl_addr <= inst_q[15:12];
                default: tbl_addr <= tbl_addr;
            endcase
        end
    end

    assign ld_a  = in_id && (id_cnt == 3'd2);
    assign ld_b  = in_id && (id_cnt == 3'd3);
    assign ld_c  = in_id && (id_cnt == 3'd4);
    assign ld_op = in_id && (id_cnt == 3'd5);

    assign opcode     = inst_q[mctl_pkg::inst_w-1 -: 3];
    assign flag       = inst_q[11];
    assign start_word = tbl_rdata;
    assign busy       = in_id || (phase == mctl_pkg::ph_ex);

endmodule

/* source/matrix_ctrl.sv */
`timescale 1ns/1ps

module matrix_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [mctl_pkg::inst_w-1:0]    inst,
    input  logic                           inst_req,
    output logic                           inst_ack,
    input  logic [1:0]                     level,
    output logic [mctl_pkg::tbl_idx_w-1:0] tbl_addr,
    input  logic [mctl_pkg::start_w-1:0]   tbl_rdata,
    input  logic [mctl_pkg::data_w-1:0]    macs_result,
    input  logic [mctl_pkg::data_w-1:0]    data_encode,
    input  logic [mctl_pkg::data_w-1:0]    data_decode,
    output logic [mctl_pkg::addr_w-1:0]    bank0_addr,
    output logic [mctl_pkg::addr_w-1:0]    bank1_addr,
    output logic [mctl_pkg::addr_w-1:0]    bank2_addr,
    output logic [mctl_pkg::addr_w-1:0]    bank3_addr,
    output logic                           bank0_wr_en,
    output logic                           bank1_wr_en,
    output logic                           bank2_wr_en,
    output logic                           bank3_wr_en,
    output logic [mctl_pkg::data_w-1:0]    wr_data,
    output logic                           mac_en,
    output logic                           busy
);

    logic [2:0]                    opcode;
    logic                          flag;
    logic [mctl_pkg::start_w-1:0]  start_word;
    logic                          ld_a;
    logic                          ld_b;
    logic                          ld_c;
    logic                          ld_op;
    logic                          ex_start;
    logic                          done;
    logic [mctl_pkg::start_w-1:0]  a_start;
    logic [mctl_pkg::start_w-1:0]  b_start;
    logic [mctl_pkg::start_w-1:0]  c_start;
    logic [mctl_pkg::start_w-1:0]  d_start;
    logic [1:0]                    wr_src;
    logic [1:0]                    wr_bank;
    logic [mctl_pkg::upc_w-1:0]    upc_start;
    logic [mctl_pkg::loop_w-1:0]   outer_cnt;
    logic [mctl_pkg::loop_w-1:0]   inner_cnt;
    logic                          step_ab;
    logic                          wen;
    logic                          step_d;

    inst_fetch u_fetch (
        .clk        (clk),
        .rstn       (rstn),
        .inst       (inst),
        .inst_req   (inst_req),
        .inst_ack   (inst_ack),
        .tbl_addr   (tbl_addr),
        .tbl_rdata  (tbl_rdata),
        .opcode     (opcode),
        .flag       (flag),
        .start_word (start_word),
        .ld_a       (ld_a),
        .ld_b       (ld_b),
        .ld_c       (ld_c),
        .ld_op      (ld_op),
        .ex_start   (ex_start),
        .done       (done),
        .busy       (busy)
    );

    op_config u_cfg (
        .clk        (clk),
        .rstn       (rstn),
        .level      (level),
        .opcode     (opcode),
        .flag       (flag),
        .start_word (start_word),
        .ld_a       (ld_a),
        .ld_b       (ld_b),
        .ld_c       (ld_c),
        .ld_op      (ld_op),
        .a_start    (a_start),
        .b_start    (b_start),
        .c_start    (c_start),
        .d_start    (d_start),
        .wr_src     (wr_src),
        .wr_bank    (wr_bank),
        .upc_start  (upc_start),
        .outer_cnt  (outer_cnt),
        .inner_cnt  (inner_cnt)
    );

    useq u_useq (
        .clk        (clk),
        .rstn       (rstn),
        .ex_start   (ex_start),
        .upc_start  (upc_start),
        .outer_cnt  (outer_cnt),
        .inner_cnt  (inner_cnt),
        .done       (done),
        .mac_en     (mac_en),
        .step_ab    (step_ab),
        .wen        (wen),
        .step_d     (step_d)
    );

    agu u_agu (
        .clk         (clk),
        .rstn        (rstn),
        .ex_start    (ex_start),
        .a_start     (a_start),
        .b_start     (b_start),
        .d_start     (d_start),
        .wr_src      (wr_src),
        .wr_bank     (wr_bank),
        .mac_en      (mac_en),
        .step_ab     (step_ab),
        .wen         (wen),
        .step_d      (step_d),
        .macs_result (macs_result),
        .data_encode (data_encode),
        .data_decode (data_decode),
        .bank0_addr  (bank0_addr),
        .bank1_addr  (bank1_addr),
        .bank2_addr  (bank2_addr),
        .bank3_addr  (bank3_addr),
        .bank0_wr_en (bank0_wr_en),
        .bank1_wr_en (bank1_wr_en),
        .bank2_wr_en (bank2_wr_en),
        .bank3_wr_en (bank3_wr_en),
        .wr_data     (wr_data)
    );

endmodule

/* source/mctl_pkg.sv */
package mctl_pkg;

    localparam int inst_w    = 27; // {op[26:24], a[23:20], b[19:16], c[15:12], flag[11], ...}
    localparam int addr_w    = 12;
    localparam int start_w   = 14; // {bank[1:0], addr[11:0]}
    localparam int tbl_idx_w = 4;
    localparam int data_w    = 64;
    localparam int upc_w     = 6;
    localparam int uinst_w   = 8;
    localparam int loop_w    = 6;

    // controller phases
    localparam logic [1:0] ph_idle = 2'b00;
    localparam logic [1:0] ph_if   = 2'b01;
    localparam logic [1:0] ph_id   = 2'b10;
    localparam logic [1:0] ph_ex   = 2'b11;

    localparam logic [2:0] op_mac   = 3'b100;
    localparam logic [2:0] op_codec = 3'b110;

    localparam logic [1:0] src_none = 2'd0;
    localparam logic [1:0] src_mac  = 2'd1;
    localparam logic [1:0] src_enc  = 2'd2;
    localparam logic [1:0] src_dec  = 2'd3;

    // microinstruction bit positions, bit 7 spare
    localparam int uf_done      = 0;
    localparam int uf_loop_end  = 1;
    localparam int uf_mac_en    = 2;
    localparam int uf_step_ab   = 3;
    localparam int uf_wen       = 4;
    localparam int uf_step_d    = 5;
    localparam int uf_inner_end = 6;

    localparam logic [upc_w-1:0] upc_mac   = 6'd0;
    localparam logic [upc_w-1:0] upc_nop   = 6'd2; // bare done word
    localparam logic [upc_w-1:0] upc_codec = 6'd3;

    // outer loop counts per security level
    localparam logic [loop_w-1:0] mac_outer_lv1 = 6'd21;
    localparam logic [loop_w-1:0] mac_outer_lv2 = 6'd15;
    localparam logic [loop_w-1:0] mac_outer_lv3 = 6'd10;
    localparam logic [loop_w-1:0] mac_inner     = 6'd4;
    localparam logic [loop_w-1:0] codec_outer   = 6'd16;

    localparam logic [2:0] id_cycles = 3'd6;

endpackage

/* source/op_config.sv */
`timescale 1ns/1ps

module op_config (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [1:0]                    level,
    input  logic [2:0]                    opcode,
    input  logic                          flag,
    input  logic [mctl_pkg::start_w-1:0]  start_word,
    input  logic                          ld_a,
    input  logic                          ld_b,
    input  logic                          ld_c,
    input  logic                          ld_op,
    output logic [mctl_pkg::start_w-1:0]  a_start,
    output logic [mctl_pkg::start_w-1:0]  b_start,
    output logic [mctl_pkg::start_w-1:0]  c_start,
    output logic [mctl_pkg::start_w-1:0]  d_start,
    output logic [1:0]                    wr_src,
    output logic [1:0]                    wr_bank,
    output logic [mctl_pkg::upc_w-1:0]    upc_start,
    output logic [mctl_pkg::loop_w-1:0]   outer_cnt,
    output logic [mctl_pkg::loop_w-1:0]   inner_cnt
);

    logic [mctl_pkg::loop_w-1:0] mac_outer;

    always_comb begin
        case (level)
            2'd1:    mac_outer = mctl_pkg::mac_outer_lv1;
            2'd2:    mac_outer = mctl_pkg::mac_outer_lv2;
            2'd3:    mac_outer = mctl_pkg::mac_outer_lv3;
            default: mac_outer = '0;    // level 0 runs no loops
        endcase
    end

    always_ff @(posedge clk) begin
        if (ld_a)
            a_start <= start_word;
        if (ld_b)
            b_start <= start_word;
        if (ld_c)
            c_start <= start_word;
    end

    // result goes to the partner bank of C
    assign d_start = {c_start[mctl_pkg::start_w-1], ~c_start[mctl_pkg::start_w-2],
                      c_start[mctl_pkg::addr_w-1:0]};
    assign wr_bank = d_start[mctl_pkg::start_w-1:mctl_pkg::addr_w];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_src    <= mctl_pkg::src_none;
            upc_start <= mctl_pkg::upc_nop;
            outer_cnt <= '0;
            inner_cnt <= '0;
        end else if (ld_op) begin
            case (opcode)
                mctl_pkg::op_mac: begin
                    wr_src    <= mctl_pkg::src_mac;
                    upc_start <= mctl_pkg::upc_mac;
                    outer_cnt <= mac_outer;
                    inner_cnt <= mctl_pkg::mac_inner;
                end
                mctl_pkg::op_codec: begin
                    wr_src    <= flag ? mctl_pkg::src_dec : mctl_pkg::src_enc;
                    upc_start <= mctl_pkg::upc_codec;
                    outer_cnt <= mctl_pkg::codec_outer;
                    inner_cnt <= '0;
                end
                default: begin
                    wr_src    <= mctl_pkg::src_none;
                    upc_start <= mctl_pkg::upc_nop;
                    outer_cnt <= '0;
                    inner_cnt <= '0;
                end
            endcase
        end
    end

endmodule

/* source/useq.sv */
`timescale 1ns/1ps

module useq (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         ex_start,
    input  logic [mctl_pkg::upc_w-1:0]   upc_start,
    input  logic [mctl_pkg::loop_w-1:0]  outer_cnt,
    input  logic [mctl_pkg::loop_w-1:0]  inner_cnt,
    output logic                         done,
    output logic                         mac_en,
    output logic                         step_ab,
    output logic                         wen,
    output logic                         step_d
);

    logic [mctl_pkg::upc_w-1:0]   upc;
    logic [mctl_pkg::uinst_w-1:0] uinst;
    logic [mctl_pkg::loop_w-1:0]  outer_left;
    logic [mctl_pkg::loop_w-1:0]  inner_left;
    logic                         running;

    // bits: spare, inner_end, step_d, wen, step_ab, mac_en, loop_end, done
    always_comb begin
        case (upc)
            6'd0:    uinst = 8'b0100_1100;  // mac body, repeats per inner count
            6'd1:    uinst = 8'b0011_0010;  // write mac result
            6'd2:    uinst = 8'b0000_0001;
            6'd3:    uinst = 8'b0011_0010;  // codec write
            6'd4:    uinst = 8'b0000_0001;
            default: uinst = 8'b0000_0001;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            running    <= 1'b0;
            upc        <= '0;
            outer_left <= '0;
            inner_left <= '0;
        end else if (ex_start) begin
            running    <= 1'b1;
            upc        <= (outer_cnt == '0) ? mctl_pkg::upc_nop : upc_start;
            outer_left <= outer_cnt;
            inner_left <= inner_cnt;
        end else if (running) begin
            if (uinst[mctl_pkg::uf_done]) begin
                running <= 1'b0;
            end else if (uinst[mctl_pkg::uf_inner_end]) begin
                if (inner_left == 1) begin
                    inner_left <= inner_cnt;   // rearm for next outer pass
                    upc        <= upc + 1;
                end else begin
                    inner_left <= inner_left - 1;
                end
            end else if (uinst[mctl_pkg::uf_loop_end]) begin
                if (outer_left == 1) begin
                    upc <= upc + 1;
                end else begin
                    outer_left <= outer_left - 1;
                    upc        <= upc_start;
                end
            end else begin
                upc <= upc + 1;
            end
        end
    end

    assign done    = running && uinst[mctl_pkg::uf_done];
    assign mac_en  = running && uinst[mctl_pkg::uf_mac_en];
    assign step_ab = running && uinst[mctl_pkg::uf_step_ab];
    assign wen     = running && uinst[mctl_pkg::uf_wen];
    assign step_d  = running && uinst[mctl_pkg::uf_step_d];

endmodule

/* verif/matrix_ctrl_assert.sv */
`timescale 1ns/1ps

module matrix_ctrl_assert (
    input logic clk,
    input logic rstn,
    input logic inst_req,
    input logic inst_ack,
    input logic mac_en,
    input logic busy,
    input logic bank0_wr_en,
    input logic bank1_wr_en,
    input logic bank2_wr_en,
    input logic bank3_wr_en
);

    logic [3:0] wr_en;

    assign wr_en = {bank3_wr_en, bank2_wr_en, bank1_wr_en, bank0_wr_en};

    a_one_bank: assert property (@(posedge clk) disable iff (!rstn) $onehot0(wr_en))
        else $error("more than one bank write enable high");

    // ack may only answer a request seen at the previous edge
    a_ack_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without inst_req");

    a_busy: assert property (@(posedge clk) disable iff (!rstn)
        (mac_en || (wr_en != 4'b0000)) |-> busy)
        else $error("mac_en or write enable while not busy");

endmodule

bind matrix_ctrl matrix_ctrl_assert u_assert (
    .clk         (clk),
    .rstn        (rstn),
    .inst_req    (inst_req),
    .inst_ack    (inst_ack),
    .mac_en      (mac_en),
    .busy        (busy),
    .bank0_wr_en (bank0_wr_en),
    .bank1_wr_en (bank1_wr_en),
    .bank2_wr_en (bank2_wr_en),
    .bank3_wr_en (bank3_wr_en)
);

/* verif/tb_matrix_ctrl.sv */
`timescale 1ns/1ps

module tb_matrix_ctrl;

    localparam int n_inst      = 12;
    localparam int clk_period  = 40;
    localparam int rst_cycles  = 8;
    localparam int inst_budget = 21 * 4 + 40;   // cycles per instruction for the longest mac

    logic                           clk = 1'b0;
    logic                           rstn;
    logic [mctl_pkg::inst_w-1:0]    inst;
    logic                           inst_req;
    logic                           inst_ack;
    logic [1:0]                     level;
    logic [mctl_pkg::tbl_idx_w-1:0] tbl_addr;
    logic [mctl_pkg::start_w-1:0]   tbl_rdata;
    logic [63:0]                    macs_result;
    logic [63:0]                    data_encode;
    logic [63:0]                    data_decode;
    logic [11:0]                    bank0_addr;
    logic [11:0]                    bank1_addr;
    logic [11:0]                    bank2_addr;
    logic [11:0]                    bank3_addr;
    logic                           bank0_wr_en;
    logic                           bank1_wr_en;
    logic                           bank2_wr_en;
    logic                           bank3_wr_en;
    logic [63:0]                    wr_data;
    logic                           mac_en;
    logic                           busy;

    logic [15:0] lfsr;
    logic [13:0] desc_mem [16];
    logic [3:0]  addr_q = '0;
    logic [3:0]  wr_vec;
    logic [3:0]  idx_a;
    logic [3:0]  idx_b;
    logic [3:0]  idx_c;
    logic [1:0]  exp_bank;
    logic [11:0] d_next;
    logic [1:0]  a_bank;
    logic [1:0]  b_bank;
    logic [11:0] a_next;
    logic [11:0] b_next;
    logic        cur_flag;
    int          cur_kind;      // 0 mac, 1 codec, 2 no-op
    int          exp_wr;
    int          exp_mac;
    int          wr_seen = 0;
    int          mac_seen = 0;
    int          busy_falls = 0;
    int          cyc_since_ack = 1000;
    logic        ack_q = 1'b0;
    logic        req_q = 1'b0;
    logic        busy_q = 1'b0;
    int          err_val = 0;
    int          err_proto = 0;

    matrix_ctrl dut (.*);

    assign wr_vec = {bank3_wr_en, bank2_wr_en, bank1_wr_en, bank0_wr_en};

    always #(clk_period / 2) clk = ~clk;

    // 16 bit fibonacci with taps 16 14 13 11
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [11:0] port_addr(input logic [1:0] b);
        case (b)
            2'd0:    return bank0_addr;
            2'd1:    return bank1_addr;
            2'd2:    return bank2_addr;
            default: return bank3_addr;
        endcase
    endfunction

    function automatic logic [63:0] exp_data();
        if (cur_kind == 0)
            return macs_result;
        if (cur_flag)
            return data_decode;
        return data_encode;
    endfunction

    task automatic value_error(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        err_val++;
    endtask

    task automatic protocol_error(input string msg);
        $display("protocol failure at %0t: %s", $time, msg);
        err_proto++;
    endtask

    // descriptor table answers one clock late
    always @(posedge clk) begin
        #2;
        tbl_rdata   = desc_mem[addr_q];
        addr_q      = tbl_addr;
        macs_result = rand_bits(64);    // data inputs change every cycle
        data_encode = rand_bits(64);
        data_decode = rand_bits(64);
    end

    always @(negedge clk) begin
        if (rstn) begin
            if (inst_ack && !ack_q) begin
                if (!req_q)
                    protocol_error("inst_ack rose without inst_req");
                cyc_since_ack = 0;
            end else if (cyc_since_ack < 1000) begin
                cyc_since_ack++;
            end
            if (!inst_ack && ack_q && req_q)
                protocol_error("inst_ack fell while inst_req was still high");
            if (busy_q && !busy)
                busy_falls++;
            if (cyc_since_ack == 1 && tbl_addr != idx_a)
                value_error("tbl_addr for A", tbl_addr, idx_a);
            if (cyc_since_ack == 2 && tbl_addr != idx_b)
                value_error("tbl_addr for B", tbl_addr, idx_b);
            if (cyc_since_ack == 3 && tbl_addr != idx_c)
                value_error("tbl_addr for C", tbl_addr, idx_c);
            if (wr_vec != 4'b0000) begin
                if (!busy || cyc_since_ack < 7)
                    protocol_error("write enable outside EX");
                if (wr_vec != 4'(1 << exp_bank))
                    value_error("bank write enables", wr_vec, 4'(1 << exp_bank));
                if (port_addr(exp_bank) != d_next)
                    value_error("write address", port_addr(exp_bank), d_next);
                if (wr_data != exp_data())
                    value_error("wr_data", wr_data, exp_data());
                d_next = d_next + 12'd1;
                wr_seen++;
            end
            if (mac_en) begin
                if (!busy || cyc_since_ack < 7)
                    protocol_error("mac_en outside EX");
                if (port_addr(a_bank) != a_next)
                    value_error("A stream address", port_addr(a_bank), a_next);
                if (b_bank != a_bank && port_addr(b_bank) != b_next)
                    value_error("B stream address", port_addr(b_bank), b_next);
                a_next = a_next + 12'd1;    // one A and one B element per mac
                b_next = b_next + 12'd1;
                mac_seen++;
            end
        end
        ack_q  = inst_ack;
        req_q  = inst_req;
        busy_q = busy;
    end

    task automatic wait_ack(input logic val, input string what);
        int n;
        n = 0;
        while (inst_ack !== val && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (inst_ack !== val)
            protocol_error($sformatf("inst_ack did not go to %0d after %s", val, what));
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < 200) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy !== 1'b0)
            protocol_error("busy never fell after the instruction");
    endtask

    task automatic run_inst(input int i);
        logic [2:0]  op;
        logic        f;
        logic [1:0]  lv;
        logic [3:0]  ia;
        logic [3:0]  ib;
        logic [3:0]  ic;
        logic [10:0] pad;
        logic [13:0] a_desc;
        logic [13:0] b_desc;
        logic [13:0] c_desc;
        int          outer;
        @(negedge clk);
        f   = 1'(rand_bits(1));
        lv  = 2'(rand_bits(2));
        ia  = 4'(rand_bits(4));
        ib  = 4'(rand_bits(4));
        ic  = 4'(rand_bits(4));
        pad = 11'(rand_bits(11));
        op  = 3'(rand_bits(3));
        if (i % 3 == 0)
            op = 3'b100;
        else if (i % 3 == 1)
            op = 3'b110;
        else if (op == 3'b100 || op == 3'b110)
            op = op ^ 3'b001;   // any other opcode is a no-op
        outer  = (lv == 2'd1) ? 21 : (lv == 2'd2) ? 15 : (lv == 2'd3) ? 10 : 0;
        a_desc = desc_mem[ia];
        b_desc = desc_mem[ib];
        c_desc = desc_mem[ic];
        @(posedge clk);
        #2;
        cur_kind = i % 3;
        cur_flag = f;
        idx_a    = ia;
        idx_b    = ib;
        idx_c    = ic;
        exp_bank = {c_desc[13], ~c_desc[12]};   // partner bank of C
        d_next   = c_desc[11:0];
        a_bank   = a_desc[13:12];
        a_next   = a_desc[11:0];
        b_bank   = b_desc[13:12];
        b_next   = b_desc[11:0];
        exp_wr   = (cur_kind == 0) ? outer : (cur_kind == 1) ? 16 : 0;
        exp_mac  = (cur_kind == 0) ? outer * 4 : 0;
        wr_seen  = 0;
        mac_seen = 0;
        level    = lv;
        inst     = {op, ia, ib, ic, f, pad};
        inst_req = 1'b1;
        wait_ack(1'b1, "inst_req rose");
        inst_req = 1'b0;
        wait_ack(1'b0, "inst_req fell");
        wait_busy_low();
        @(posedge clk);
        #2;
        if (wr_seen != exp_wr)
            value_error("write count", wr_seen, exp_wr);
        if (mac_seen != exp_mac)
            value_error("mac_en count", mac_seen, exp_mac);
        if (busy_falls != i + 1)
            protocol_error($sformatf("busy fell %0d times over %0d instructions",
                                     busy_falls, i + 1));
    endtask

    initial begin
        rstn        = 1'b0;
        inst        = '0;
        inst_req    = 1'b0;
        level       = 2'd0;
        tbl_rdata   = '0;
        macs_result = '0;
        data_encode = '0;
        data_decode = '0;
        idx_a       = '0;
        idx_b       = '0;
        idx_c       = '0;
        exp_bank    = '0;
        d_next      = '0;
        a_bank      = '0;
        a_next      = '0;
        b_bank      = '0;
        b_next      = '0;
        cur_kind    = 2;
        cur_flag    = 1'b0;
        lfsr        = 16'd27046;
        for (int k = 0; k < 16; k++)
            desc_mem[k] = 14'(rand_bits(14));
        repeat (rst_cycles) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        if (inst_ack || busy || mac_en || wr_vec != 4'b0000)
            protocol_error("outputs not idle after reset");
        for (int i = 0; i < n_inst; i++)
            run_inst(i);
        repeat (2) @(posedge clk);
        $display("errors: value %0d, protocol %0d", err_val, err_proto);
        if (err_val == 0 && err_proto == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog
    initial begin
        #((rst_cycles + 10 + n_inst * inst_budget) * clk_period);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("Some tests failed");
        $finish;
    end

endmodule
